//--- src/stage_pkg.sv
// Shared types for stage 0; buffer address width fixed at 7 bits, sample is signed 24.8
`default_nettype none

package stage_pkg;

  // Buffer address width, must equal LEN_W + DEPTH_W at the top level
  localparam int BUF_ADDR_W = 7;

  // --------------------------------------------------
  // Sample word
  // --------------------------------------------------

  // 24.8 fixed point, integer part signed
  typedef struct packed {
    logic signed [23:0] int_part;
    logic [7:0]         frac_part;
  } sample_t;

  // Pass kind tagged on each output beat
  typedef enum logic [0:0] {
    PASS_FORWARD = 1'b0,
    PASS_ERROR   = 1'b1
  } pass_e;

  // Tap sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE = 2'd0,
    SEQ_READ = 2'd1,
    SEQ_NEXT = 2'd2
  } seq_state_e;

  // --------------------------------------------------
  // Buffer request and output beat
  // --------------------------------------------------

  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [BUF_ADDR_W-1:0] address;
    sample_t               data;
  } buf_req_t;

  typedef struct packed {
    sample_t    data;
    logic [3:0] tap_address;
    logic [3:0] bias_address;
    pass_e      kind;
    logic       last;    // final word of a pass
  } out_beat_t;

endpackage

`default_nettype wire

//--- src/burst_loader.sv
// Input loader; holds at most load_depth blocks in load_depth+1 slots, in_ready low one cycle after reset
`timescale 1ns/1ps
`default_nettype none

module burst_loader #(
  parameter int LEN_W   = 3,
  parameter int DEPTH_W = 4
) (
  input  wire                 clk,
  input  wire                 reset,
  input  stage_pkg::sample_t  in_data,
  input  wire                 in_valid,
  input  wire [LEN_W-1:0]     load_length,
  input  wire [DEPTH_W-1:0]   load_depth,
  input  wire                 block_done,
  output logic                in_ready,
  output stage_pkg::buf_req_t wr_req,
  output logic                blocks_held_nz
);

  logic [LEN_W-1:0]   word_cnt;
  logic [DEPTH_W-1:0] block_cnt;
  logic [DEPTH_W-1:0] held;
  logic [DEPTH_W-1:0] held_next;
  logic               ready_q;
  logic               accept;
  logic               block_fill;

  assign accept     = in_valid & ready_q;
  assign block_fill = accept & (word_cnt == load_length);

  // --------------------------------------------------
  // Word and block counters
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      word_cnt  <= '0;
      block_cnt <= '0;
    end else if (accept) begin
      if (block_fill) begin
        word_cnt <= '0;
        // Slot index wraps after load_depth
        if (block_cnt == load_depth) begin
          block_cnt <= '0;
        end else begin
          block_cnt <= block_cnt + DEPTH_W'(1);
        end
      end else begin
        word_cnt <= word_cnt + LEN_W'(1);
      end
    end
  end

  // --------------------------------------------------
  // Held-block credit
  // --------------------------------------------------

  // Fill and release together leave the count unchanged
  always_comb begin
    case ({block_fill, block_done})
      2'b10:   held_next = held + DEPTH_W'(1);
      2'b01:   held_next = held - DEPTH_W'(1);
      default: held_next = held;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      held    <= '0;
      ready_q <= 1'b0;
    end else begin
      held    <= held_next;
      ready_q <= (held_next != load_depth);
    end
  end

  assign in_ready       = ready_q;
  assign blocks_held_nz = (held != '0);

  // Write goes out in the accepting cycle
  assign wr_req.valid   = accept;
  assign wr_req.write   = 1'b1;
  assign wr_req.address = {block_cnt, word_cnt};
  assign wr_req.data    = in_data;

  // Credit never overruns the configured depth
  held_in_range_a: assert property (
    @(posedge clk) disable iff (reset) held <= load_depth
  );

endmodule

`default_nettype wire

//--- src/tap_sequencer.sv
// Tap sequencer; learn and state_length must stay stable for a whole block, at most 4 forward passes
`timescale 1ns/1ps
`default_nettype none

module tap_sequencer #(
  parameter int LEN_W   = 3,
  parameter int DEPTH_W = 4
) (
  input  wire                  clk,
  input  wire                  reset,
  input  wire [LEN_W-1:0]      load_length,
  input  wire [DEPTH_W-1:0]    load_depth,
  input  wire [1:0]            state_length,
  input  wire                  learn,
  input  wire                  blocks_held_nz,
  input  wire                  rd_grant,
  output stage_pkg::buf_req_t  rd_req,
  output stage_pkg::out_beat_t rd_meta,
  output logic                 block_done
);

  stage_pkg::seq_state_e state;
  logic [LEN_W-1:0]      word_cnt;
  logic [2:0]            pass_cnt;
  logic [DEPTH_W-1:0]    rd_blk;
  logic                  final_word;
  logic                  is_err;
  logic                  final_pass;

  // --------------------------------------------------
  // Pass decode
  // --------------------------------------------------

  assign final_word = (word_cnt == load_length);
  // Only reachable with learn high
  assign is_err     = (pass_cnt > {1'b0, state_length});
  assign final_pass = learn ? is_err : (pass_cnt == {1'b0, state_length});

  // --------------------------------------------------
  // State machine
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= stage_pkg::SEQ_IDLE;
      word_cnt <= '0;
      pass_cnt <= '0;
      rd_blk   <= '0;
    end else begin
      case (state)
        stage_pkg::SEQ_IDLE: begin
          if (blocks_held_nz) begin
            state <= stage_pkg::SEQ_READ;
          end
        end
        stage_pkg::SEQ_READ: begin
          // Hold the request until granted
          if (rd_grant) begin
            if (final_word) begin
              word_cnt <= '0;
              if (final_pass) begin
                pass_cnt <= '0;
                state    <= stage_pkg::SEQ_NEXT;
              end else begin
                pass_cnt <= pass_cnt + 3'd1;
              end
            end else begin
              word_cnt <= word_cnt + LEN_W'(1);
            end
          end
        end
        stage_pkg::SEQ_NEXT: begin
          // Release the block, loader credit updates this edge
          state <= stage_pkg::SEQ_IDLE;
          if (rd_blk == load_depth) begin
            rd_blk <= '0;
          end else begin
            rd_blk <= rd_blk + DEPTH_W'(1);
          end
        end
        default: begin
          state <= stage_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  assign block_done = (state == stage_pkg::SEQ_NEXT);

  // --------------------------------------------------
  // Read request and beat metadata
  // --------------------------------------------------

  assign rd_req.valid   = (state == stage_pkg::SEQ_READ);
  assign rd_req.write   = 1'b0;
  assign rd_req.address = {rd_blk, word_cnt};
  assign rd_req.data    = '0;

  assign rd_meta.data         = '0;
  assign rd_meta.tap_address  = 4'(word_cnt);
  assign rd_meta.bias_address = 4'(pass_cnt);
  assign rd_meta.kind         = is_err ? stage_pkg::PASS_ERROR : stage_pkg::PASS_FORWARD;
  assign rd_meta.last         = final_word;

  block_done_pulse_a: assert property (
    @(posedge clk) disable iff (reset) block_done |=> !block_done
  );

  idle_no_read_a: assert property (
    @(posedge clk) disable iff (reset) (state == stage_pkg::SEQ_IDLE) |-> !rd_req.valid
  );

endmodule

`default_nettype wire

//--- src/buffer_arbiter.sv
// Buffer port arbiter; writes always win, no output back-pressure so every beat must be taken
`timescale 1ns/1ps
`default_nettype none

module buffer_arbiter (
  input  wire                  clk,
  input  wire                  reset,
  input  stage_pkg::buf_req_t  wr_req,
  input  stage_pkg::buf_req_t  rd_req,
  input  stage_pkg::out_beat_t rd_meta,
  input  stage_pkg::sample_t   mem_rdata,
  output logic                 rd_grant,
  output stage_pkg::buf_req_t  mem_req,
  output logic                 out_valid,
  output stage_pkg::out_beat_t out_beat
);

  stage_pkg::out_beat_t meta_q;
  logic                 pend_q;

  // Fixed priority, a read only goes in a write-free cycle
  assign rd_grant = rd_req.valid & ~wr_req.valid;
  assign mem_req  = wr_req.valid ? wr_req : rd_req;

  // --------------------------------------------------
  // Beat tracking
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= rd_grant;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_grant) begin
      meta_q <= rd_meta;
    end
  end

  // Memory data lands the cycle after the grant, same as meta_q
  always_comb begin
    out_beat      = meta_q;
    out_beat.data = mem_rdata;
  end

  assign out_valid = pend_q;

  grant_excl_write_a: assert property (
    @(posedge clk) disable iff (reset) rd_grant |-> !wr_req.valid
  );

endmodule

`default_nettype wire

//--- src/sample_buffer.sv
// Single-port sample memory, no reset on contents; read data is registered and held between reads
`timescale 1ns/1ps
`default_nettype none

module sample_buffer #(
  parameter int LEN_W   = 3,
  parameter int DEPTH_W = 4,
  parameter int WORD_W  = 32
) (
  input  wire                 clk,
  input  stage_pkg::buf_req_t mem_req,
  output stage_pkg::sample_t  mem_rdata
);

  localparam int ADDR_W = LEN_W + DEPTH_W;

  logic [WORD_W-1:0] mem [0:(2**ADDR_W)-1];
  logic [WORD_W-1:0] rdata_q;
  logic [ADDR_W-1:0] addr;

  assign addr = mem_req.address;

  // --------------------------------------------------
  // Port access
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (mem_req.valid) begin
      if (mem_req.write) begin
        mem[addr] <= mem_req.data;
      end else begin
        rdata_q <= mem[addr];
      end
    end
  end

  assign mem_rdata = rdata_q;

endmodule

`default_nettype wire

//--- src/stage0_top.sv
// Stage 0 control and buffer; load_depth must be nonzero, config inputs held stable while running
`timescale 1ns/1ps
`default_nettype none

module stage0_top #(
  parameter int LEN_W   = 3,
  parameter int DEPTH_W = 4,
  parameter int WORD_W  = 32
) (
  input  wire                  clk,
  input  wire                  reset,
  input  stage_pkg::sample_t   in_data,
  input  wire                  in_valid,
  input  wire [LEN_W-1:0]      load_length,
  input  wire [DEPTH_W-1:0]    load_depth,
  input  wire [1:0]            state_length,
  input  wire                  learn,
  output logic                 in_ready,
  output logic                 out_valid,
  output stage_pkg::out_beat_t out_beat
);

  stage_pkg::buf_req_t  wr_req;
  stage_pkg::buf_req_t  rd_req;
  stage_pkg::buf_req_t  mem_req;
  stage_pkg::out_beat_t rd_meta;
  stage_pkg::sample_t   mem_rdata;
  logic                 rd_grant;
  logic                 block_done;
  logic                 blocks_held_nz;

  // --------------------------------------------------
  // Write side
  // --------------------------------------------------

  burst_loader #(
    .LEN_W   (LEN_W),
    .DEPTH_W (DEPTH_W)
  ) loader_i (
    .clk            (clk),
    .reset          (reset),
    .in_data        (in_data),
    .in_valid       (in_valid),
    .load_length    (load_length),
    .load_depth     (load_depth),
    .block_done     (block_done),
    .in_ready       (in_ready),
    .wr_req         (wr_req),
    .blocks_held_nz (blocks_held_nz)
  );

  // --------------------------------------------------
  // Read side
  // --------------------------------------------------

  tap_sequencer #(
    .LEN_W   (LEN_W),
    .DEPTH_W (DEPTH_W)
  ) sequencer_i (
    .clk            (clk),
    .reset          (reset),
    .load_length    (load_length),
    .load_depth     (load_depth),
    .state_length   (state_length),
    .learn          (learn),
    .blocks_held_nz (blocks_held_nz),
    .rd_grant       (rd_grant),
    .rd_req         (rd_req),
    .rd_meta        (rd_meta),
    .block_done     (block_done)
  );

  buffer_arbiter arbiter_i (
    .clk       (clk),
    .reset     (reset),
    .wr_req    (wr_req),
    .rd_req    (rd_req),
    .rd_meta   (rd_meta),
    .mem_rdata (mem_rdata),
    .rd_grant  (rd_grant),
    .mem_req   (mem_req),
    .out_valid (out_valid),
    .out_beat  (out_beat)
  );

  sample_buffer #(
    .LEN_W   (LEN_W),
    .DEPTH_W (DEPTH_W),
    .WORD_W  (WORD_W)
  ) buffer_i (
    .clk       (clk),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

//--- verification/stage0_tb.sv
// Testbench; run from the project root so the data file resolves, the DUT is reset before each test
`timescale 1ns/1ps
`default_nettype none

module stage0_tb;

  localparam int LEN_W       = 3;
  localparam int DEPTH_W     = 4;
  localparam int WORD_W      = 32;
  localparam int FILE_WORDS  = 512;
  localparam int TEST_CYCLES = 2000;
  localparam int READY_WAIT  = 10;
  localparam int QUIET_WAIT  = 8;

  logic                 clk;
  logic                 reset;
  stage_pkg::sample_t   in_data;
  logic                 in_valid;
  logic [LEN_W-1:0]     load_length;
  logic [DEPTH_W-1:0]   load_depth;
  logic [1:0]           state_length;
  logic                 learn;
  logic                 in_ready;
  logic                 out_valid;
  stage_pkg::out_beat_t out_beat;

  // Data file image and the test being run
  logic [47:0]          tdata [0:FILE_WORDS-1];
  int                   pos;
  stage_pkg::sample_t   word_q [$];
  stage_pkg::out_beat_t beat_q [$];
  logic [LEN_W-1:0]     cfg_len;
  logic [DEPTH_W-1:0]   cfg_depth;
  logic [1:0]           cfg_state;
  logic                 cfg_learn;
  logic                 cfg_gap;
  int                   cfg_blocks;

  int errors;
  int tests_failed;

  stage0_top #(
    .LEN_W   (LEN_W),
    .DEPTH_W (DEPTH_W),
    .WORD_W  (WORD_W)
  ) dut_i (
    .clk          (clk),
    .reset        (reset),
    .in_data      (in_data),
    .in_valid     (in_valid),
    .load_length  (load_length),
    .load_depth   (load_depth),
    .state_length (state_length),
    .learn        (learn),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_beat     (out_beat)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // --------------------------------------------------
  // Data file decode
  // --------------------------------------------------

  // Beat entry is data(8 hex) tap bias kind last
  function automatic stage_pkg::out_beat_t entry_to_beat(input logic [47:0] e);
    stage_pkg::out_beat_t b;
    b.data         = stage_pkg::sample_t'(e[47:16]);
    b.tap_address  = e[15:12];
    b.bias_address = e[11:8];
    b.kind         = stage_pkg::pass_e'(e[4]);
    b.last         = e[0];
    return b;
  endfunction

  function automatic bit load_test();
    logic [47:0] head;
    int          n;
    int          n_words;
    int          passes;
    head = tdata[pos];
    if (head[47:44] !== 4'hC) begin
      return 1'b0;
    end
    cfg_len    = LEN_W'(head[43:40]);
    cfg_depth  = DEPTH_W'(head[39:36]);
    cfg_state  = head[33:32];
    cfg_learn  = head[28];
    cfg_blocks = int'(head[27:20]);
    cfg_gap    = head[16];
    // Forward passes plus the error pass when learning
    passes  = int'(cfg_state) + (cfg_learn ? 2 : 1);
    n_words = cfg_blocks * (int'(cfg_len) + 1);
    word_q.delete();
    beat_q.delete();
    pos++;
    for (n = 0; n < n_words; n++) begin
      word_q.push_back(stage_pkg::sample_t'(tdata[pos][31:0]));
      pos++;
    end
    for (n = 0; n < n_words * passes; n++) begin
      beat_q.push_back(entry_to_beat(tdata[pos]));
      pos++;
    end
    return 1'b1;
  endfunction

  // --------------------------------------------------
  // Reset and start-up
  // --------------------------------------------------

  task automatic apply_reset();
    int n;
    @(posedge clk);
    reset        <= 1'b1;
    in_valid     <= 1'b0;
    load_length  <= cfg_len;
    load_depth   <= cfg_depth;
    state_length <= cfg_state;
    learn        <= cfg_learn;
    for (n = 0; n < 2; n++) begin
      @(posedge clk);
    end
    reset <= 1'b0;
  endtask

  task automatic await_ready(output bit ok);
    int n;
    ok = 1'b0;
    for (n = 0; n < READY_WAIT && !ok; n++) begin
      @(posedge clk);
      if (out_valid) begin
        $display("ERR %0t: out_valid high before any input", $time);
        errors++;
      end
      if (n == 0 && in_ready) begin
        $display("ERR %0t: in_ready high in the first cycle after reset", $time);
        errors++;
      end
      if (in_ready) begin
        ok = 1'b1;
      end
    end
  endtask

  task automatic show_mismatch(input int test_no, input int beat_no,
                               input stage_pkg::out_beat_t got,
                               input stage_pkg::out_beat_t want);
    $display("ERR %0t: test %0d beat %0d got data %h tap %0d bias %0d kind %0d last %0d",
             $time, test_no, beat_no, got.data, got.tap_address, got.bias_address,
             got.kind, got.last);
    $display("    expected data %h tap %0d bias %0d kind %0d last %0d",
             want.data, want.tap_address, want.bias_address, want.kind, want.last);
  endtask

  // --------------------------------------------------
  // Stimulus and beat checking
  // --------------------------------------------------

  task automatic run_test(input int test_no);
    int  cycle;
    int  fed;
    int  seen;
    int  n;
    int  n_words;
    int  n_beats;
    int  block_words;
    int  start_errors;
    bit  took;
    bit  stall_seen;
    start_errors = errors;
    n_words      = word_q.size();
    n_beats      = beat_q.size();
    block_words  = int'(cfg_len) + 1;
    fed          = 0;
    seen         = 0;
    cycle        = 0;
    stall_seen   = 1'b0;
    in_data  <= word_q[0];
    in_valid <= 1'b1;
    while ((fed < n_words || seen < n_beats) && cycle < TEST_CYCLES) begin
      @(posedge clk);
      cycle++;
      if (out_valid) begin
        if (seen >= n_beats) begin
          $display("Test %0d: unexpected extra beat at %0t", test_no, $time);
          errors++;
        end else begin
          // A block is read only once all its words are in
          if (fed < (seen / (n_beats / cfg_blocks) + 1) * block_words) begin
            $display("Test %0d: beat %0d came before its block was loaded", test_no, seen);
            errors++;
          end
          if (out_beat !== beat_q[seen]) begin
            show_mismatch(test_no, seen, out_beat, beat_q[seen]);
            errors++;
          end
          seen++;
        end
      end
      took = in_valid && in_ready;
      if (in_valid && !in_ready) begin
        stall_seen = 1'b1;
      end
      if (took) begin
        fed++;
      end
      if (fed < n_words) begin
        in_data  <= word_q[fed];
        in_valid <= !(cfg_gap && took);
      end else begin
        in_valid <= 1'b0;
      end
    end
    if (fed < n_words || seen < n_beats) begin
      $display("Test %0d: timed out with %0d of %0d words taken and %0d of %0d beats seen",
               test_no, fed, n_words, seen, n_beats);
      errors++;
    end
    for (n = 0; n < QUIET_WAIT; n++) begin
      @(posedge clk);
      if (out_valid) begin
        $display("Test %0d: unexpected extra beat at %0t", test_no, $time);
        errors++;
      end
    end
    // Continuous input must fill every slot before the sequencer gets a read in
    if (!cfg_gap && cfg_blocks > int'(cfg_depth) && !stall_seen) begin
      $display("Test %0d: in_ready never dropped with load_depth blocks held", test_no);
      errors++;
    end
    if (errors != start_errors) begin
      tests_failed++;
      $display("Test %0d: FAILED, %0d beats seen", test_no, seen);
    end else begin
      $display("Test %0d: ok, %0d beats seen", test_no, seen);
    end
  endtask

  initial begin
    bit ok;
    int test_no;
    reset        = 1'b1;
    in_data      = '0;
    in_valid     = 1'b0;
    load_length  = '0;
    load_depth   = DEPTH_W'(1);
    state_length = '0;
    learn        = 1'b0;
    errors       = 0;
    tests_failed = 0;
    pos          = 0;
    test_no      = 0;
    $readmemh("verification/stage0_testdata.txt", tdata);
    while (load_test()) begin
      test_no++;
      apply_reset();
      await_ready(ok);
      if (!ok) begin
        $display("Test %0d: in_ready never rose after reset", test_no);
        errors++;
        tests_failed++;
      end else begin
        run_test(test_no);
      end
    end
    if (test_no == 0) begin
      $display("No tests found in the data file");
      errors++;
    end
    $display("Tests %0d, failed %0d, errors %0d", test_no, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/stage_pkg.sv
src/burst_loader.sv
src/tap_sequencer.sv
src/buffer_arbiter.sv
src/sample_buffer.sv
src/stage0_top.sv
verification/stage0_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the stage 0 testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module stage0_tb \
  -f all.f -o stage0_sim > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/stage0_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$SIM_LOG"; then
  exit 1
fi
exit 0

//--- verification/stage0_testdata.txt
// Header: C, load_length, load_depth, state_length, learn, blocks (2 digits), gap mode, 0000
// Then input words, one line per block; then beats, one line per pass: data(8) tap bias kind last
// Gap mode 1 leaves in_valid low for one cycle after each accepted word

// One block, one pass
C32000100000
00000100 00000200 00000300 00000400
000001000000 000002001000 000003002000 000004003001

// Three forward passes per block, negative sample
C12200200000
FFFFFF80 00001A40
00000001 7FFFFF00
FFFFFF800000 00001A401001
FFFFFF800100 00001A401101
FFFFFF800200 00001A401201
000000010000 7FFFFF001001
000000010100 7FFFFF001101
000000010200 7FFFFF001201

// Learn, two forward passes then the error pass, gapped input
C23110110000
00000A00 00000B00 00000C00
00000A000000 00000B001000 00000C002001
00000A000100 00000B001100 00000C002101
00000A000210 00000B001210 00000C002211

// More blocks than load_depth under continuous input, slot index wraps twice
C11100400000
00010000 00020000
00030000 00040000
00050000 00060000
00070000 00080000
000100000000 000200001001
000100000100 000200001101
000300000000 000400001001
000300000100 000400001101
000500000000 000600001001
000500000100 000600001101
000700000000 000800001001
000700000100 000800001101

// Gapped input interleaved with reads, learn on
C22010310000
00000011 00000012 00000013
00000021 00000022 00000023
00000031 00000032 00000033
000000110000 000000121000 000000132001
000000110110 000000121110 000000132111
000000210000 000000221000 000000232001
000000210110 000000221110 000000232111
000000310000 000000321000 000000332001
000000310110 000000321110 000000332111

// End of tests
000000000000
